/* sources.f */
+incdir+hw
hw/i2c_pkg.sv
hw/eeprom_pkg.sv
hw/scl_gen.sv
hw/i2c_byte_engine.sv
hw/eeprom_sequencer.sv
hw/eeprom_ctrl_top.sv
test/eeprom_bus_model.sv
test/eeprom_ctrl_props.sv
test/tb_eeprom_ctrl.sv

/* Bender.yml */
package:
  name: eeprom_ctrl

sources:
  - include_dirs:
      - hw
    files:
      - hw/i2c_pkg.sv
      - hw/eeprom_pkg.sv
      - hw/scl_gen.sv
      - hw/i2c_byte_engine.sv
      - hw/eeprom_sequencer.sv
      - hw/eeprom_ctrl_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/eeprom_bus_model.sv
      - test/eeprom_ctrl_props.sv
      - test/tb_eeprom_ctrl.sv

/* test/tb_eeprom_ctrl.sv */
`timescale 1ns/1ps
`include "eeprom_config.svh"

module tb_eeprom_ctrl
    import i2c_pkg::*;
    import eeprom_pkg::*;
();

    localparam int N_TRANS        = 24;
    localparam int SCL_PERIOD     = 4 * `EE_SCL_QUARTER;
    localparam int TIMEOUT_CYCLES = N_TRANS * 30 * SCL_PERIOD + N_TRANS * 200;

    logic     CLK = 1'b0;
    logic     RESET;
    logic     wr;
    logic     rd;
    ee_addr_t addr;
    ee_data_t wdata;
    logic     busy;
    logic     done;
    logic     nack_err;
    ee_data_t rdata;
    logic     scl;
    logic     sda_low;
    logic     sda;
    logic     present;
    ee_addr_t model_addr;
    logic     model_err;

    ee_data_t shadow [0:`EE_MEM_BYTES-1];   // expected memory contents
    ee_addr_t wa [0:7];
    integer   seed;
    int       err_count;
    int       check_count;
    int       test_count;
    int       cycle_count = 0;
    int       done_count = 0;

    always #20 CLK = ~CLK;

    eeprom_ctrl_top u_dut
    (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wdata    (wdata),
        .sda_in   (sda),
        .busy     (busy),
        .done     (done),
        .nack_err (nack_err),
        .rdata    (rdata),
        .scl      (scl),
        .sda_low  (sda_low)
    );

    eeprom_bus_model u_model
    (
        .scl       (scl),
        .sda_low   (sda_low),
        .present   (present),
        .sda       (sda),
        .last_addr (model_addr),
        .proto_err (model_err)
    );

    always @(posedge CLK)
    begin
        if (done === 1'b1)
            done_count <= done_count + 1;
    end

    always @(posedge CLK)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d cycles, the tests did not finish", cycle_count);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic check_data(input string name, input ee_data_t got, input ee_data_t exp);
        check_count++;
        if (got !== exp)
        begin
            err_count++;
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp)
        begin
            err_count++;
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input ee_addr_t got, input ee_addr_t exp);
        check_count++;
        if (got !== exp)
        begin
            err_count++;
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        if (err_count == errs_before)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, err_count - errs_before);
    endtask

    task automatic strobe_write(input ee_addr_t a, input ee_data_t d);
        @(posedge CLK);
        wr    <= 1'b1;
        addr  <= a;
        wdata <= d;
        @(posedge CLK);
        wr <= 1'b0;
    endtask

    task automatic strobe_read(input ee_addr_t a);
        @(posedge CLK);
        rd   <= 1'b1;
        addr <= a;
        @(posedge CLK);
        rd <= 1'b0;
    endtask

    // wait for done and the return to idle
    task automatic finish_transaction;
        @(posedge CLK);
        while (done !== 1'b1)
            @(posedge CLK);
        while (busy !== 1'b0)
            @(posedge CLK);
    endtask

    task automatic write_byte(input ee_addr_t a, input ee_data_t d, output logic nerr);
        strobe_write(a, d);
        finish_transaction();
        nerr = nack_err;
    endtask

    task automatic read_byte(input ee_addr_t a, output ee_data_t d, output logic nerr);
        strobe_read(a);
        finish_transaction();
        d    = rdata;
        nerr = nack_err;
    endtask

    task automatic test_reset;
        int errs_before;
        errs_before = err_count;
        check_flag("scl", scl, 1'b1);
        check_flag("sda_low", sda_low, 1'b0);
        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);
        report_test("reset state", errs_before);
    endtask

    task automatic test_write_read;
        int       errs_before;
        int       blk;
        ee_addr_t a;
        ee_data_t d;
        logic     nerr;
        errs_before = err_count;
        for (blk = 0; blk < 8; blk++)
        begin
            a       = {blk[2:0], i2c_byte_t'($random(seed))};
            d       = ee_data_t'($random(seed));
            wa[blk] = a;
            write_byte(a, d, nerr);
            shadow[a] = d;
            check_flag("nack_err", nerr, 1'b0);
            check_addr("model last_addr", model_addr, a);
        end
        for (blk = 0; blk < 8; blk++)
        begin
            read_byte(wa[blk], d, nerr);
            check_data("rdata", d, shadow[wa[blk]]);
            check_flag("nack_err", nerr, 1'b0);
            check_addr("model last_addr", model_addr, wa[blk]);
        end
        report_test("write then read back", errs_before);
    endtask

    task automatic test_overwrite;
        int       errs_before;
        ee_addr_t a;
        ee_data_t d1;
        ee_data_t d;
        logic     nerr;
        errs_before = err_count;
        a  = 11'h5c3;
        d1 = ee_data_t'($random(seed));
        write_byte(a, d1, nerr);
        write_byte(a, ~d1, nerr);
        shadow[a] = ~d1;
        read_byte(a, d, nerr);
        check_data("rdata", d, ~d1);
        check_flag("nack_err", nerr, 1'b0);
        report_test("overwrite", errs_before);
    endtask

    task automatic test_absent;
        int       errs_before;
        ee_addr_t a;
        ee_data_t d;
        logic     nerr;
        errs_before = err_count;
        a = wa[3];
        @(posedge CLK);
        present <= 1'b0;
        write_byte(a, ~shadow[a], nerr);
        check_flag("nack_err on write", nerr, 1'b1);
        read_byte(a, d, nerr);
        check_flag("nack_err on read", nerr, 1'b1);
        @(posedge CLK);
        present <= 1'b1;
        read_byte(a, d, nerr);
        check_data("rdata", d, shadow[a]);
        check_flag("nack_err", nerr, 1'b0);
        report_test("absent device", errs_before);
    endtask

    task automatic test_busy_strobe;
        int       errs_before;
        int       dones_before;
        ee_data_t d;
        logic     nerr;
        errs_before  = err_count;
        dones_before = done_count;
        strobe_read(wa[5]);
        repeat (40) @(posedge CLK);
        check_flag("busy", busy, 1'b1);
        strobe_write(wa[6], ~shadow[wa[6]]);   // must be dropped
        finish_transaction();
        check_data("rdata", rdata, shadow[wa[5]]);
        check_flag("nack_err", nack_err, 1'b0);
        // long enough for a queued write to show up
        repeat (40 * SCL_PERIOD) @(posedge CLK);
        check_count++;
        if (done_count != dones_before + 1)
        begin
            err_count++;
            $display("expected one done for the read, saw %0d", done_count - dones_before);
        end
        check_flag("busy", busy, 1'b0);
        read_byte(wa[6], d, nerr);
        check_data("rdata", d, shadow[wa[6]]);
        report_test("strobe while busy", errs_before);
    endtask

    task automatic test_bus_rules;
        int errs_before;
        int fails;
        errs_before = err_count;
        check_flag("model protocol error", model_err, 1'b0);
        fails = u_dut.u_seq.u_props.fail_count + u_dut.u_eng.u_props.fail_count;
        check_count++;
        if (fails != 0)
        begin
            err_count++;
            $display("bound assertions failed %0d times", fails);
        end
        report_test("bus rules", errs_before);
    endtask

    initial
    begin
        seed        = 22;
        err_count   = 0;
        check_count = 0;
        test_count  = 0;
        RESET       = 1'b1;
        wr          = 1'b0;
        rd          = 1'b0;
        addr        = '0;
        wdata       = '0;
        present     = 1'b1;
        repeat (5) @(posedge CLK);
        RESET <= 1'b0;
        @(posedge CLK);
        test_reset();
        test_write_read();
        test_overwrite();
        test_absent();
        test_busy_strobe();
        test_bus_rules();
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
        if (err_count == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

/* test/eeprom_ctrl_props.sv */
`timescale 1ns/1ps

module eeprom_ctrl_props
(
    input logic CLK,
    input logic RESET,
    input logic busy,
    input logic done,
    input logic cmd_valid,
    input logic eng_idle,
    input logic scl,
    input logic sda_low,
    input logic bus_cond    // engine framing a start or stop
);

    int fail_count = 0;

    done_one_cycle: assert property (@(posedge CLK) disable iff (RESET) done |=> !done)
    else
    begin
        $error("done stayed high for more than one cycle");
        fail_count++;
    end

    done_after_busy: assert property (@(posedge CLK) disable iff (RESET) done |-> $past(busy))
    else
    begin
        $error("done without busy on the cycle before");
        fail_count++;
    end

    cmd_when_idle: assert property (@(posedge CLK) disable iff (RESET) cmd_valid |-> eng_idle)
    else
    begin
        $error("cmd_valid while the engine is not idle");
        fail_count++;
    end

    sda_with_scl_low: assert property (@(posedge CLK) disable iff (RESET)
        (!bus_cond && !$stable(sda_low)) |-> !scl)
    else
    begin
        $error("sda_low changed with scl high outside start or stop");
        fail_count++;
    end

endmodule

// sequencer has no bus pins
bind eeprom_sequencer eeprom_ctrl_props u_props
(
    .CLK       (CLK),
    .RESET     (RESET),
    .busy      (busy),
    .done      (done),
    .cmd_valid (cmd_valid),
    .eng_idle  (eng_idle),
    .scl       (1'b0),
    .sda_low   (1'b0),
    .bus_cond  (1'b0)
);

bind i2c_byte_engine eeprom_ctrl_props u_props
(
    .CLK       (CLK),
    .RESET     (RESET),
    .busy      (1'b0),
    .done      (1'b0),
    .cmd_valid (cmd_valid),
    .eng_idle  (idle),
    .scl       (scl),
    .sda_low   (sda_low),
    .bus_cond  (state == i2c_pkg::ENG_START || state == i2c_pkg::ENG_STOP)
);

/* test/eeprom_bus_model.sv */
`timescale 1ns/1ps
`include "eeprom_config.svh"

module eeprom_bus_model
    import i2c_pkg::*;
    import eeprom_pkg::*;
(
    input  logic     scl,
    input  logic     sda_low,
    input  logic     present,
    output logic     sda,
    output ee_addr_t last_addr,
    output logic     proto_err
);

    typedef enum {M_IDLE, M_DEV, M_ADDR, M_WDATA, M_RDATA, M_WAIT} mode_t;

    ee_data_t  mem [0:`EE_MEM_BYTES-1];
    mode_t     mode;
    mode_t     mode_nxt;
    i2c_byte_t shreg;
    i2c_byte_t out_byte;
    ee_addr_t  ptr;
    int        bit_cnt;
    logic      pull_low;
    logic      scl_q;
    logic      sda_q;

    assign sda = ~(sda_low | pull_low);     // wired open drain

    initial
    begin
        int i;
        for (i = 0; i < `EE_MEM_BYTES; i++)
            mem[i] = ee_data_t'(i ^ (i >> 3) ^ 'h5a);
        mode      = M_IDLE;
        mode_nxt  = M_IDLE;
        shreg     = '0;
        out_byte  = '0;
        ptr       = '0;
        bit_cnt   = 0;
        pull_low  = 1'b0;
        scl_q     = 1'b1;
        sda_q     = 1'b1;
        last_addr = '0;
        proto_err = 1'b0;
    end

    task automatic bus_start;
        if (mode != M_IDLE && mode != M_WAIT && bit_cnt > 1)
            proto_err = 1'b1;       // start inside a byte
        mode     = M_DEV;
        bit_cnt  = 0;
        pull_low = 1'b0;
    endtask

    task automatic bus_stop;
        if (mode != M_IDLE && mode != M_WAIT)
            proto_err = 1'b1;
        mode     = M_IDLE;
        bit_cnt  = 0;
        pull_low = 1'b0;
    endtask

    // ack decision once the eighth bit is in
    task automatic take_byte;
        logic ack;
        ack      = 1'b0;
        mode_nxt = M_WAIT;
        case (mode)
            M_DEV:
                if (present && shreg[7:4] == `EE_DEV_CODE)
                begin
                    ack = 1'b1;
                    if (shreg[0])
                    begin
                        if (shreg[3:1] != ptr[10:8])
                            proto_err = 1'b1;   // block bits differ from the dummy write
                        last_addr = ptr;
                        out_byte  = mem[ptr];
                        mode_nxt  = M_RDATA;
                    end
                    else
                    begin
                        ptr[10:8] = shreg[3:1];
                        mode_nxt  = M_ADDR;
                    end
                end
            M_ADDR:
            begin
                ack       = 1'b1;
                ptr[7:0]  = shreg;
                last_addr = ptr;
                mode_nxt  = M_WDATA;
            end
            default:
            begin
                ack      = 1'b1;
                mem[ptr] = shreg;   // single byte write
            end
        endcase
        pull_low = ack;
    endtask

    task automatic clock_rise;
        case (mode)
            M_DEV, M_ADDR, M_WDATA:
            begin
                if (bit_cnt < 8)
                    shreg = {shreg[6:0], sda};
                bit_cnt = bit_cnt + 1;
            end
            M_RDATA:
            begin
                if (bit_cnt == 8 && sda !== 1'b1)
                    proto_err = 1'b1;   // master must nack the only byte
                bit_cnt = bit_cnt + 1;
            end
            default:
                bit_cnt = bit_cnt;
        endcase
    endtask

    task automatic clock_fall;
        case (mode)
            M_DEV, M_ADDR, M_WDATA:
                if (bit_cnt == 8)
                    take_byte();
                else if (bit_cnt == 9)
                begin
                    bit_cnt  = 0;
                    mode     = mode_nxt;
                    pull_low = (mode == M_RDATA) ? ~out_byte[7] : 1'b0;
                end
            M_RDATA:
                if (bit_cnt >= 1 && bit_cnt <= 7)
                    pull_low = ~out_byte[7 - bit_cnt];
                else if (bit_cnt == 8)
                    pull_low = 1'b0;    // master answers
                else if (bit_cnt == 9)
                    mode = M_WAIT;
            default:
                pull_low = 1'b0;
        endcase
    endtask

    always @(scl or sda)
    begin
        if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b1 && sda === 1'b0)
            bus_start();
        else if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b0 && sda === 1'b1)
            bus_stop();
        else if (scl === 1'b1 && scl_q === 1'b0)
            clock_rise();
        else if (scl === 1'b0 && scl_q === 1'b1)
            clock_fall();
        scl_q = scl;
        sda_q = sda;
    end

endmodule

/* hw/eeprom_ctrl_top.sv */
`timescale 1ns/1ps

module eeprom_ctrl_top
    import eeprom_pkg::*;
(
    input  logic     CLK,
    input  logic     RESET,
    input  logic     wr,
    input  logic     rd,
    input  ee_addr_t addr,
    input  ee_data_t wdata,
    input  logic     sda_in,
    output logic     busy,
    output logic     done,
    output logic     nack_err,
    output ee_data_t rdata,
    output logic     scl,
    output logic     sda_low
);

    logic               cmd_valid;
    logic               cmd_done;
    logic               eng_idle;
    logic               ack_ok;
    i2c_pkg::i2c_cmd_t  cmd;
    i2c_pkg::i2c_byte_t tx_byte;
    i2c_pkg::i2c_byte_t rx_byte;

    eeprom_sequencer u_seq
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wdata     (wdata),
        .eng_idle  (eng_idle),
        .cmd_done  (cmd_done),
        .rx_byte   (rx_byte),
        .ack_ok    (ack_ok),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .tx_byte   (tx_byte),
        .busy      (busy),
        .done      (done),
        .nack_err  (nack_err),
        .rdata     (rdata)
    );

    i2c_byte_engine u_eng
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .tx_byte   (tx_byte),
        .sda_in    (sda_in),
        .idle      (eng_idle),
        .cmd_done  (cmd_done),
        .rx_byte   (rx_byte),
        .ack_ok    (ack_ok),
        .sda_low   (sda_low),
        .scl       (scl)
    );

endmodule

/* hw/eeprom_sequencer.sv */
`timescale 1ns/1ps
`include "eeprom_config.svh"

module eeprom_sequencer
    import eeprom_pkg::*;
    import i2c_pkg::*;
(
    input  logic      CLK,
    input  logic      RESET,
    input  logic      wr,
    input  logic      rd,
    input  ee_addr_t  addr,
    input  ee_data_t  wdata,
    input  logic      eng_idle,
    input  logic      cmd_done,
    input  i2c_byte_t rx_byte,
    input  logic      ack_ok,
    output logic      cmd_valid,
    output i2c_cmd_t  cmd,
    output i2c_byte_t tx_byte,
    output logic      busy,
    output logic      done,
    output logic      nack_err,
    output ee_data_t  rdata
);

    ee_seq_state_t state;
    ee_seq_state_t state_nxt;
    logic          issue;
    i2c_cmd_t      cmd_nxt;
    i2c_byte_t     tx_nxt;
    logic          accept;
    logic          nack_now;
    logic          rd_q;
    ee_addr_t      addr_q;
    ee_data_t      wdata_q;
    i2c_byte_t     ctrl_wr;
    i2c_byte_t     ctrl_rd;

    assign accept   = (state == SEQ_IDLE) && (wr || rd) && eng_idle;
    assign nack_now = cmd_done && !ack_ok;
    assign busy     = (state != SEQ_IDLE);
    assign ctrl_wr  = {`EE_DEV_CODE, addr_q[10:8], 1'b0};
    assign ctrl_rd  = {`EE_DEV_CODE, addr_q[10:8], 1'b1};

    always_comb
    begin
        state_nxt = state;
        issue     = 1'b0;
        cmd_nxt   = CMD_STOP;   // every nack exit goes to stop
        tx_nxt    = ctrl_wr;
        case (state)
            SEQ_IDLE:
                if (accept)
                begin
                    state_nxt = SEQ_START;
                    issue     = 1'b1;
                    cmd_nxt   = CMD_START;
                end
            SEQ_START:
                if (cmd_done)
                begin
                    state_nxt = SEQ_CTRL_WR;
                    issue     = 1'b1;
                    cmd_nxt   = CMD_WRITE;
                end
            SEQ_CTRL_WR:
                if (nack_now)
                begin
                    state_nxt = SEQ_STOP;
                    issue     = 1'b1;
                end
                else if (cmd_done)
                begin
                    state_nxt = SEQ_ADDR;
                    issue     = 1'b1;
                    cmd_nxt   = CMD_WRITE;
                    tx_nxt    = addr_q[7:0];
                end
            SEQ_ADDR:
                if (nack_now)
                begin
                    state_nxt = SEQ_STOP;
                    issue     = 1'b1;
                end
                else if (cmd_done)
                begin
                    issue = 1'b1;
                    if (rd_q)
                    begin
                        state_nxt = SEQ_RESTART;
                        cmd_nxt   = CMD_START;
                    end
                    else
                    begin
                        state_nxt = SEQ_DATA_WR;
                        cmd_nxt   = CMD_WRITE;
                        tx_nxt    = wdata_q;
                    end
                end
            SEQ_RESTART:
                if (cmd_done)
                begin
                    state_nxt = SEQ_CTRL_RD;
                    issue     = 1'b1;
                    cmd_nxt   = CMD_WRITE;
                    tx_nxt    = ctrl_rd;
                end
            SEQ_CTRL_RD:
                if (nack_now)
                begin
                    state_nxt = SEQ_STOP;
                    issue     = 1'b1;
                end
                else if (cmd_done)
                begin
                    state_nxt = SEQ_DATA_RD;
                    issue     = 1'b1;
                    cmd_nxt   = CMD_READ;
                end
            SEQ_DATA_WR, SEQ_DATA_RD:
                if (cmd_done)
                begin
                    state_nxt = SEQ_STOP;
                    issue     = 1'b1;
                end
            SEQ_STOP:
                if (cmd_done)
                    state_nxt = SEQ_FINISH;
            default:
                state_nxt = SEQ_IDLE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= SEQ_IDLE;
            cmd_valid <= 1'b0;
            done      <= 1'b0;
            nack_err  <= 1'b0;
        end
        else
        begin
            state     <= state_nxt;
            cmd_valid <= issue;
            done      <= (state == SEQ_STOP) && cmd_done;
            if (accept)
                nack_err <= 1'b0;
            else if (nack_now)
                nack_err <= 1'b1;   // sticks until the next request
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            rd_q    <= !wr;     // wr wins a tie
            addr_q  <= addr;
            wdata_q <= wdata;
        end
        if (issue)
        begin
            cmd     <= cmd_nxt;
            tx_byte <= tx_nxt;
        end
        if (state == SEQ_DATA_RD && cmd_done)
            rdata <= rx_byte;
    end

endmodule

/* hw/i2c_byte_engine.sv */
`timescale 1ns/1ps

module i2c_byte_engine
    import i2c_pkg::*;
(
    input  logic      CLK,
    input  logic      RESET,
    input  logic      cmd_valid,
    input  i2c_cmd_t  cmd,
    input  i2c_byte_t tx_byte,
    input  logic      sda_in,
    output logic      idle,
    output logic      cmd_done,
    output i2c_byte_t rx_byte,
    output logic      ack_ok,
    output logic      sda_low,
    output logic      scl
);

    i2c_eng_state_t state;
    i2c_byte_t      shreg;
    logic [3:0]     bit_cnt;    // clocks started in this command
    logic           run;
    logic           bus_own;    // set once a start has taken the bus
    logic           cmd_end;
    logic           gen_scl;
    logic           scl_rise;
    logic           scl_high_mid;
    logic           scl_fall;
    logic           scl_low_mid;

    scl_gen u_scl_gen
    (
        .CLK          (CLK),
        .RESET        (RESET),
        .run          (run),
        .scl          (gen_scl),
        .scl_rise     (scl_rise),
        .scl_high_mid (scl_high_mid),
        .scl_fall     (scl_fall),
        .scl_low_mid  (scl_low_mid)
    );

    // between commands an owned bus keeps scl low so no stray clock goes out
    assign scl  = bus_own ? (run & gen_scl) : 1'b1;
    assign idle = (state == ENG_IDLE);

    assign cmd_end = scl_low_mid &&
                     (state == ENG_START || state == ENG_STOP ||
                      state == ENG_ACK_IN || state == ENG_NACK_OUT);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= ENG_IDLE;
            run      <= 1'b0;
            bus_own  <= 1'b0;
            sda_low  <= 1'b0;
            cmd_done <= 1'b0;
            ack_ok   <= 1'b0;
            bit_cnt  <= 4'd0;
        end
        else
        begin
            cmd_done <= 1'b0;
            if (scl_rise)
                bit_cnt <= bit_cnt + 4'd1;
            case (state)
                ENG_IDLE:
                    if (cmd_valid)
                    begin
                        run     <= 1'b1;
                        bit_cnt <= 4'd0;
                        ack_ok  <= 1'b1;
                        // scl is already low here on an owned bus
                        case (cmd)
                            CMD_START:
                            begin
                                state   <= ENG_START;
                                sda_low <= 1'b0;
                            end
                            CMD_STOP:
                            begin
                                state   <= ENG_STOP;
                                sda_low <= 1'b1;
                            end
                            CMD_WRITE:
                            begin
                                state   <= ENG_BIT_OUT;
                                sda_low <= ~tx_byte[7];     // msb first
                            end
                            default:
                            begin
                                state   <= ENG_BIT_IN;
                                sda_low <= 1'b0;
                            end
                        endcase
                    end
                ENG_START:
                begin
                    if (scl_high_mid)
                        sda_low <= 1'b1;    // sda falls with scl high
                    if (scl_fall)
                        bus_own <= 1'b1;
                end
                ENG_STOP:
                    if (scl_high_mid)
                    begin
                        sda_low <= 1'b0;    // sda rises with scl high
                        bus_own <= 1'b0;
                    end
                ENG_BIT_OUT:
                    if (scl_low_mid)
                    begin
                        if (bit_cnt == 4'd8)
                        begin
                            sda_low <= 1'b0;    // let the slave ack
                            state   <= ENG_ACK_IN;
                        end
                        else
                            sda_low <= ~shreg[7];
                    end
                ENG_ACK_IN:
                    if (scl_high_mid)
                        ack_ok <= ~sda_in;
                ENG_BIT_IN:
                    if (scl_low_mid && bit_cnt == 4'd8)
                        state <= ENG_NACK_OUT;  // line stays released for the nack
                default:
                    state <= state;
            endcase
            if (cmd_end)
            begin
                state    <= ENG_IDLE;
                run      <= 1'b0;
                cmd_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == ENG_IDLE && cmd_valid)
            shreg <= {tx_byte[6:0], 1'b0};
        else if (state == ENG_BIT_OUT && scl_low_mid)
            shreg <= {shreg[6:0], 1'b0};
        else if (state == ENG_BIT_IN && scl_high_mid)
            shreg <= {shreg[6:0], sda_in};
        if (state == ENG_NACK_OUT && cmd_end)
            rx_byte <= shreg;
    end

endmodule

/* hw/scl_gen.sv */
`timescale 1ns/1ps
`include "eeprom_config.svh"

module scl_gen
(
    input  logic CLK,
    input  logic RESET,
    input  logic run,
    output logic scl,
    output logic scl_rise,
    output logic scl_high_mid,
    output logic scl_fall,
    output logic scl_low_mid
);

    localparam int QUARTER = `EE_SCL_QUARTER;
    localparam int QW      = $clog2(QUARTER + 1);

    logic [QW-1:0] qcnt;
    logic [1:0]    phase;
    logic          qend;

    assign qend = (qcnt == QW'(QUARTER - 1));

    // period is low, high, high, low; idle parks high
    assign scl = ~run | (phase == 2'd1) | (phase == 2'd2);

    always_ff @(posedge CLK)
    begin
        if (RESET || !run)
        begin
            qcnt         <= '0;
            phase        <= 2'd0;
            scl_rise     <= 1'b0;
            scl_high_mid <= 1'b0;
            scl_fall     <= 1'b0;
            scl_low_mid  <= 1'b0;
        end
        else
        begin
            // strobe lands on the first cycle of the new phase
            scl_rise     <= qend && (phase == 2'd0);
            scl_high_mid <= qend && (phase == 2'd1);
            scl_fall     <= qend && (phase == 2'd2);
            scl_low_mid  <= qend && (phase == 2'd3);
            if (qend)
            begin
                qcnt  <= '0;
                phase <= phase + 2'd1;
            end
            else
                qcnt <= qcnt + QW'(1);
        end
    end

endmodule

/* hw/eeprom_pkg.sv */
`include "eeprom_config.svh"

package eeprom_pkg;

    // bits 10..8 go out in the device-select byte
    typedef logic [$clog2(`EE_MEM_BYTES)-1:0] ee_addr_t;

    typedef logic [7:0] ee_data_t;

    typedef enum logic [3:0]
    {
        SEQ_IDLE,
        SEQ_START,
        SEQ_CTRL_WR,
        SEQ_ADDR,
        SEQ_DATA_WR,
        SEQ_RESTART,
        SEQ_CTRL_RD,
        SEQ_DATA_RD,
        SEQ_STOP,
        SEQ_FINISH      // done pulse
    } ee_seq_state_t;

endpackage

/* hw/i2c_pkg.sv */
package i2c_pkg;

    typedef logic [7:0] i2c_byte_t;

    // commands the byte engine runs, one at a time
    typedef enum logic [1:0]
    {
        CMD_START,
        CMD_STOP,
        CMD_WRITE,
        CMD_READ
    } i2c_cmd_t;

    typedef enum logic [2:0]
    {
        ENG_IDLE,
        ENG_START,
        ENG_STOP,
        ENG_BIT_OUT,
        ENG_ACK_IN,     // ninth clock of a write
        ENG_BIT_IN,
        ENG_NACK_OUT    // ninth clock of a read
    } i2c_eng_state_t;

endpackage

/* hw/eeprom_config.svh */
`ifndef EEPROM_CONFIG_SVH
`define EEPROM_CONFIG_SVH

// CLK cycles per quarter of an SCL period
`define EE_SCL_QUARTER 2

// 16 kbit part of the 24C16 class
`define EE_MEM_BYTES 2048

// upper nibble of the device-select byte
`define EE_DEV_CODE 4'b1010

`endif
